//--- rvExecUnit.f
source/rvPkg.sv
source/instrDecode.sv
source/aluExecute.sv
source/resultCommit.sv
source/wbInstrPort.sv
source/rvExecUnit.sv
+incdir+sim
sim/rvExecTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module rvExecTb \
    -f rvExecUnit.f -o rvExecSim

out=$(./obj_dir/rvExecSim)
echo "$out"
echo "$out" | grep -qx "Test passed"

//--- sim/rvModel.svh
`ifndef RVMODEL_SVH
`define RVMODEL_SVH

// Architectural state of the RV32I reference model
logic [31:0] modelRegs [0:31];
logic [31:0] modelPc;
logic        modelIllegal;

task automatic modelReset(input logic [31:0] startPc);
    for (int i = 0; i < 32; i++) begin
        modelRegs[i] = 32'b0;
    end
    modelPc      = startPc;
    modelIllegal = 1'b0;
endtask

// Integer op selected by funct3, alt picks SUB or SRA
function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] x, input logic [31:0] y);
    logic [31:0] r;
    case (f3)
        3'd0: r = alt ? x - y : x + y;
        3'd1: r = x << y[4:0];
        3'd2: r = {31'b0, $signed(x) < $signed(y)};
        3'd3: r = {31'b0, x < y};
        3'd4: r = x ^ y;
        3'd5: begin
            if (alt) r = $signed(x) >>> y[4:0];
            else r = x >> y[4:0];
        end
        3'd6: r = x | y;
        default: r = x & y;
    endcase
    return r;
endfunction

function automatic logic branchModel(input logic [2:0] f3, input logic [31:0] x,
                                     input logic [31:0] y);
    case (f3)
        3'd0: return x == y;
        3'd1: return x != y;
        3'd4: return $signed(x) < $signed(y);
        3'd5: return $signed(x) >= $signed(y);
        3'd6: return x < y;
        3'd7: return x >= y;
        default: return 1'b0;
    endcase
endfunction

// Executes one instruction word on the model state
task automatic modelStep(input logic [31:0] ins);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic [31:0] res;
    logic [31:0] next;
    logic        bad;
    logic        wr;
    rd   = ins[11:7];
    rs1  = ins[19:15];
    opc  = ins[6:2];
    f3   = ins[14:12];
    f7   = ins[31:25];
    a    = modelRegs[rs1];
    b    = modelRegs[ins[24:20]];
    immI = {{20{ins[31]}}, ins[31:20]};
    res  = 32'b0;
    next = modelPc + 32'd4;
    wr   = 1'b1;
    bad  = ins[1:0] != 2'b11;
    case (opc)
        rvPkg::OP: begin
            bad = bad || !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
            res = aluModel(f3, f7[5], a, b);
        end
        rvPkg::OP_IMM: begin
            bad = bad || (f3 == 3'd1 && f7 != 7'h00);
            bad = bad || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
            res = aluModel(f3, f3 == 3'd5 && f7[5], a, immI);
        end
        rvPkg::LUI:   res = {ins[31:12], 12'b0};
        rvPkg::AUIPC: res = modelPc + {ins[31:12], 12'b0};
        rvPkg::JAL: begin
            res  = modelPc + 32'd4;
            next = modelPc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        rvPkg::JALR: begin
            bad  = bad || f3 != 3'd0;
            res  = modelPc + 32'd4;
            next = (a + immI) & ~32'd1; // Target low bit dropped
        end
        rvPkg::BRANCH: begin
            wr  = 1'b0;
            bad = bad || f3[2:1] == 2'b01;
            if (branchModel(f3, a, b)) begin
                next = modelPc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
        end
        default: bad = 1'b1;
    endcase
    if (bad) begin
        modelIllegal = 1'b1; // Nothing else changes
    end else begin
        if (wr && rd != 5'd0) begin
            modelRegs[rd] = res;
        end
        modelPc = next;
    end
endtask

`endif

//--- sim/rvExecTb.sv
`timescale 1ns/100ps

module rvExecTb;

    localparam int clkPeriod = 20;
    localparam int nOp       = 200;
    localparam int nOpImm    = 150;
    localparam int nUpper    = 20;
    localparam int nBranch   = 60;
    localparam int nJump     = 40;
    localparam int nIllegal  = 9;
    localparam int totalTx   = 2 + (62 + nOp + 33) + (2 * nOpImm + 33) + 6 * nUpper +
                               3 * nBranch + 3 * nJump + 36 * nIllegal;

    logic        clk;
    logic        rstN;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [5:0]  adr;
    logic [31:0] datW;
    logic [31:0] datR;
    logic        ack;

    logic [31:0] rngState;
    string       curTest;
    int          testChecks;
    int          testErrs;
    int          checkCount;
    int          errCount;
    int          txCount;

    `include "rvModel.svh"

    rvExecUnit #(.resetPc(32'h0000_0400)) u_rvExecUnit (
        .clk(clk), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datW(datW), .datR(datR), .ack(ack)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Generous bound of 20 cycles per bus transaction
    initial begin
        #((totalTx * 20 + 10) * clkPeriod);
        $display("Watchdog timeout: the DUT stopped answering bus requests");
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] rand32();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic logic [4:0] randReg(); // Any of x1..x31
        logic [31:0] r;
        r = rand32();
        return 5'(1 + r % 31);
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rvPkg::OP, 2'b11};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input rvPkg::OpCode opc);
        return {imm, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                         input rvPkg::OpCode opc);
        return {imm, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] i, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {i[12], i[10:5], rs2, rs1, f3, i[4:1], i[11], rvPkg::BRANCH, 2'b11};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] i, input logic [4:0] rd);
        return {i[20], i[10:1], i[11], i[19:12], rd, rvPkg::JAL, 2'b11};
    endfunction

    // Called on a falling edge, returns on a falling edge
    task automatic busCycle(input logic wr, input logic [5:0] a, input logic [31:0] d,
                            output logic [31:0] q);
        cyc  = 1'b1;
        stb  = 1'b1;
        we   = wr;
        adr  = a;
        datW = d;
        @(negedge clk);
        while (!ack) @(negedge clk);
        q = datR;
        @(negedge clk); // Hold through the ack edge
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        txCount++;
    endtask

    task automatic issueInstr(input logic [31:0] ins);
        logic [31:0] unused;
        busCycle(1'b1, rvPkg::adrInstr, ins, unused);
        modelStep(ins);
    endtask

    task automatic writePc(input logic [31:0] value);
        logic [31:0] unused;
        busCycle(1'b1, rvPkg::adrPc, value, unused);
        modelPc = value;
    endtask

    task automatic checkValue(input logic [31:0] exp, input logic [31:0] got);
        checkCount++;
        testChecks++;
        assert (got === exp) else begin
            $display("Fail %s: expected %h, got %h", curTest, exp, got);
            errCount++;
            testErrs++;
        end
    endtask

    task automatic checkReg(input logic [4:0] idx);
        logic [31:0] got;
        busCycle(1'b0, rvPkg::adrRegBase + {1'b0, idx}, 32'b0, got);
        checkValue(modelRegs[idx], got);
    endtask

    task automatic checkAllRegs();
        for (int i = 0; i < 32; i++) begin
            checkReg(5'(i));
        end
    endtask

    task automatic checkPc();
        logic [31:0] got;
        busCycle(1'b0, rvPkg::adrPc, 32'b0, got);
        checkValue(modelPc, got);
    endtask

    task automatic checkStatus(); // Reading clears the flag
        logic [31:0] got;
        busCycle(1'b0, rvPkg::adrInstr, 32'b0, got);
        checkValue({31'b0, modelIllegal}, got);
        modelIllegal = 1'b0;
    endtask

    task automatic startTest(input string name);
        curTest    = name;
        testChecks = 0;
        testErrs   = 0;
    endtask

    task automatic finishTest();
        $display("%s: %0d checks, %0d errors", curTest, testChecks, testErrs);
    endtask

    task automatic runRegRegTest();
        logic [31:0] r;
        logic [2:0]  f3;
        startTest("opRegReg");
        for (int i = 1; i < 32; i++) begin
            r = rand32();
            issueInstr(encU(r[31:12], 5'(i), rvPkg::LUI));
            issueInstr(encI(r[11:0], 5'(i), 3'b000, 5'(i), rvPkg::OP_IMM));
        end
        for (int n = 0; n < nOp; n++) begin
            r  = rand32();
            f3 = r[14:12];
            issueInstr(encR((r[30] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                            r[24:20], r[19:15], f3, r[11:7]));
        end
        checkAllRegs();
        checkPc();
        finishTest();
    endtask

    task automatic runOpImmTest();
        logic [31:0] r;
        logic [11:0] imm;
        logic [2:0]  f3;
        startTest("opImm");
        for (int n = 0; n < nOpImm; n++) begin
            r   = rand32();
            f3  = r[14:12];
            imm = r[31:20];
            if (f3 == 3'd1) imm = {7'b0, r[24:20]};
            else if (f3 == 3'd5) imm = {1'b0, r[30], 5'b0, r[24:20]}; // SRLI or SRAI
            issueInstr(encI(imm, r[19:15], f3, r[11:7], rvPkg::OP_IMM));
            checkReg(r[11:7]);
        end
        checkAllRegs();
        checkPc();
        finishTest();
    endtask

    task automatic runUpperTest();
        logic [31:0] r;
        logic [4:0]  rd;
        startTest("upperImm");
        for (int n = 0; n < nUpper; n++) begin
            r = rand32();
            writePc({r[31:2], 2'b00});
            r  = rand32();
            rd = randReg();
            issueInstr(encU(r[31:12], rd, rvPkg::LUI));
            checkReg(rd);
            r  = rand32();
            rd = randReg();
            issueInstr(encU(r[31:12], rd, rvPkg::AUIPC));
            checkReg(rd);
            checkPc();
        end
        finishTest();
    endtask

    task automatic runBranchTest();
        logic [31:0] r;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] delta;
        logic [2:0]  f3;
        startTest("branch");
        for (int n = 0; n < nBranch; n++) begin
            rs1 = randReg();
            rs2 = randReg();
            if (rs2 == rs1) rs2 = (rs1 == 5'd31) ? 5'd1 : rs1 + 5'd1;
            r     = rand32();
            delta = {1'b0, r[10:0]} | 12'd1;
            case (r[31:16] % 3)
                0: delta = 12'd0; // Equal pair
                1: delta = -delta;
                default: ;
            endcase
            issueInstr(encI(delta, rs1, 3'b000, rs2, rvPkg::OP_IMM));
            r = rand32();
            case (r[31:16] % 6)
                0: f3 = 3'd0;
                1: f3 = 3'd1;
                2: f3 = 3'd4;
                3: f3 = 3'd5;
                4: f3 = 3'd6;
                default: f3 = 3'd7;
            endcase
            issueInstr(encB({r[11:0], 1'b0}, rs2, rs1, f3));
            checkPc();
        end
        finishTest();
    endtask

    task automatic runJumpTest();
        logic [31:0] r;
        logic [4:0]  rd;
        startTest("jump");
        for (int n = 0; n < nJump; n++) begin
            r  = rand32();
            rd = (r[31:30] == 2'b00) ? 5'd0 : randReg(); // x0 link now and then
            if (n % 2 == 0) issueInstr(encJ({r[19:0], 1'b0}, rd));
            else issueInstr(encI(r[11:0], randReg(), 3'b000, rd, rvPkg::JALR));
            checkReg(rd);
            checkPc();
        end
        finishTest();
    endtask

    task automatic runIllegalTest();
        logic [31:0] r;
        logic [31:0] ins;
        startTest("illegal");
        for (int n = 0; n < nIllegal; n++) begin
            r = rand32();
            case (n)
                0: ins = encI(r[31:20], r[19:15], 3'b010, randReg(), rvPkg::LOAD);
                1: ins = encI(r[31:20], r[19:15], 3'b010, randReg(), rvPkg::STORE);
                2: ins = encI(r[31:20], r[19:15], 3'b000, randReg(), rvPkg::SYSTEM);
                3: ins = {r[31:2], 2'b00};
                4: ins = encR(7'h01, r[24:20], r[19:15], r[14:12], randReg()); // MUL group
                5: ins = encI({7'h20, r[24:20]}, r[19:15], 3'b001, randReg(), rvPkg::OP_IMM);
                6: ins = encB({r[11:0], 1'b0}, r[24:20], r[19:15], 3'b010);
                7: ins = encI(r[31:20], r[19:15], 3'b001, randReg(), rvPkg::JALR);
                default: ins = {r[31:7], 7'b1111111};
            endcase
            issueInstr(ins);
            checkAllRegs();
            checkPc();
            checkStatus();
            checkStatus();
        end
        finishTest();
    endtask

    initial begin
        rstN       = 1'b0;
        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        adr        = 6'd0;
        datW       = 32'b0;
        rngState   = 32'hcf004857;
        checkCount = 0;
        errCount   = 0;
        txCount    = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        modelReset(u_rvExecUnit.resetPc);
        startTest("reset");
        checkPc();
        checkStatus();
        finishTest();
        runRegRegTest();
        runOpImmTest();
        runUpperTest();
        runBranchTest();
        runJumpTest();
        runIllegalTest();
        $display("Summary: %0d transactions, %0d checks, %0d errors",
                 txCount, checkCount, errCount);
        if (errCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- source/rvExecUnit.sv
`timescale 1ns/100ps

module rvExecUnit #(
    parameter logic [31:0] resetPc = 32'h0
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [5:0]  adr,
    input  logic [31:0] datW,
    output logic [31:0] datR,
    output logic        ack
);

    logic [31:0]     instrWord, pcData, readVal, pc, rs1Val, rs2Val, imm, rdData, nextPc;
    logic            issue, pcWrite, statusRead, illegalFlag;
    logic [4:0]      readAddr, rs1, rs2, rd, rdAddr;
    rvPkg::AluCtrl   aluCtrl;
    rvPkg::BranchCmd branchCmd;
    logic            useImm, isBranch, isJal, isJalr, isAuipc, isLui, writesRd, illegal;
    logic            commit, rdWrite, illegalOut;

    wbInstrPort u_wbInstrPort (
        .clk(clk), .rstN(rstN), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datW(datW),
        .readVal(readVal), .pc(pc), .illegalFlag(illegalFlag), .commit(commit),
        .datR(datR), .ack(ack), .instrWord(instrWord), .issue(issue),
        .pcWrite(pcWrite), .pcData(pcData), .readAddr(readAddr), .statusRead(statusRead)
    );

    instrDecode u_instrDecode (
        .instrWord(instrWord), .rs1(rs1), .rs2(rs2), .rd(rd), .aluCtrl(aluCtrl),
        .branchCmd(branchCmd), .imm(imm), .useImm(useImm), .isBranch(isBranch),
        .isJal(isJal), .isJalr(isJalr), .isAuipc(isAuipc), .isLui(isLui),
        .writesRd(writesRd), .illegal(illegal)
    );

    aluExecute u_aluExecute (
        .clk(clk), .rstN(rstN), .issue(issue), .rd(rd), .aluCtrl(aluCtrl),
        .branchCmd(branchCmd), .imm(imm), .useImm(useImm), .isBranch(isBranch),
        .isJal(isJal), .isJalr(isJalr), .isAuipc(isAuipc), .isLui(isLui),
        .writesRd(writesRd), .illegal(illegal), .rs1Val(rs1Val), .rs2Val(rs2Val), .pc(pc),
        .commit(commit), .rdAddr(rdAddr), .rdData(rdData), .rdWrite(rdWrite),
        .nextPc(nextPc), .illegalOut(illegalOut)
    );

    resultCommit #(.resetPc(resetPc)) u_resultCommit (
        .clk(clk), .rstN(rstN), .commit(commit), .rdAddr(rdAddr), .rdData(rdData),
        .rdWrite(rdWrite), .nextPc(nextPc), .illegalOut(illegalOut), .pcWrite(pcWrite),
        .pcData(pcData), .rs1(rs1), .rs2(rs2), .readAddr(readAddr),
        .statusRead(statusRead), .rs1Val(rs1Val), .rs2Val(rs2Val), .readVal(readVal),
        .pc(pc), .illegalFlag(illegalFlag)
    );

endmodule

//--- source/wbInstrPort.sv
`timescale 1ns/100ps

module wbInstrPort (
    input  logic        clk,
    input  logic        rstN,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [5:0]  adr,
    input  logic [31:0] datW,
    input  logic [31:0] readVal,
    input  logic [31:0] pc,
    input  logic        illegalFlag,
    input  logic        commit,
    output logic [31:0] datR,
    output logic        ack,
    output logic [31:0] instrWord,
    output logic        issue,
    output logic        pcWrite,
    output logic [31:0] pcData,
    output logic [4:0]  readAddr,
    output logic        statusRead
);

    rvPkg::PortState state;
    logic        sample;
    logic        hitInstr, hitPc, hitReg;
    logic [31:0] readMux;

    assign sample   = (state == rvPkg::IDLE) && cyc && stb; // New request accepted
    assign hitInstr = adr == rvPkg::adrInstr;
    assign hitPc    = adr == rvPkg::adrPc;
    assign hitReg   = adr >= rvPkg::adrRegBase;

    assign pcWrite    = sample && we && hitPc;
    assign pcData     = datW;
    assign statusRead = sample && !we && hitInstr; // Clears flag on this edge
    assign readAddr   = adr[4:0];

    always_comb begin
        if (hitInstr) readMux = {31'b0, illegalFlag};
        else if (hitPc) readMux = pc;
        else if (hitReg) readMux = readVal;
        else readMux = 32'b0; // Unmapped
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= rvPkg::IDLE;
            ack   <= 1'b0;
            issue <= 1'b0;
        end else begin
            case (state)
                rvPkg::IDLE: begin
                    if (sample && we && hitInstr) begin
                        issue <= 1'b1;
                        state <= rvPkg::ISSUE;
                    end else if (sample) begin
                        ack   <= 1'b1; // Reads, PC and unmapped writes
                        state <= rvPkg::ACK;
                    end
                end
                rvPkg::ISSUE: begin
                    issue <= 1'b0;
                    state <= rvPkg::WAITCOMMIT;
                end
                rvPkg::WAITCOMMIT: begin
                    if (commit) begin
                        ack   <= 1'b1;
                        state <= rvPkg::ACK;
                    end
                end
                default: begin
                    ack   <= 1'b0;
                    state <= rvPkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sample && we && hitInstr) begin
            instrWord <= datW;
        end
        if (sample && !we) begin
            datR <= readMux;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) ack |-> cyc && stb)
        else $error("ack without an active request");

endmodule

//--- source/resultCommit.sv
`timescale 1ns/100ps

module resultCommit #(
    parameter logic [31:0] resetPc = 32'h0
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        commit,
    input  logic [4:0]  rdAddr,
    input  logic [31:0] rdData,
    input  logic        rdWrite,
    input  logic [31:0] nextPc,
    input  logic        illegalOut,
    input  logic        pcWrite,
    input  logic [31:0] pcData,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  readAddr,
    input  logic        statusRead,
    output logic [31:0] rs1Val,
    output logic [31:0] rs2Val,
    output logic [31:0] readVal,
    output logic [31:0] pc,
    output logic        illegalFlag
);

    logic [31:0] regs [1:31]; // x0 is not stored

    assign rs1Val  = (rs1 == 5'd0) ? 32'b0 : regs[rs1];
    assign rs2Val  = (rs2 == 5'd0) ? 32'b0 : regs[rs2];
    assign readVal = (readAddr == 5'd0) ? 32'b0 : regs[readAddr];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'b0;
            end
            pc          <= resetPc;
            illegalFlag <= 1'b0;
        end else begin
            if (commit && rdWrite && rdAddr != 5'd0) begin
                regs[rdAddr] <= rdData;
            end
            if (commit) begin
                pc <= nextPc;
            end else if (pcWrite) begin
                pc <= pcData; // Host PC write
            end
            if (commit && illegalOut) begin
                illegalFlag <= 1'b1; // Sticky until status read
            end else if (statusRead) begin
                illegalFlag <= 1'b0;
            end
        end
    end

    // Host accesses only happen while no instruction is in flight
    assert property (@(posedge clk) disable iff (!rstN) commit |-> !pcWrite && !statusRead)
        else $error("host PC write or status read collides with a commit");

endmodule

//--- source/aluExecute.sv
`timescale 1ns/100ps

module aluExecute (
    input  logic            clk,
    input  logic            rstN,
    input  logic            issue,
    input  logic [4:0]      rd,
    input  rvPkg::AluCtrl   aluCtrl,
    input  rvPkg::BranchCmd branchCmd,
    input  logic [31:0]     imm,
    input  logic            useImm,
    input  logic            isBranch,
    input  logic            isJal,
    input  logic            isJalr,
    input  logic            isAuipc,
    input  logic            isLui,
    input  logic            writesRd,
    input  logic            illegal,
    input  logic [31:0]     rs1Val,
    input  logic [31:0]     rs2Val,
    input  logic [31:0]     pc,
    output logic            commit,
    output logic [4:0]      rdAddr,
    output logic [31:0]     rdData,
    output logic            rdWrite,
    output logic [31:0]     nextPc,
    output logic            illegalOut
);

    logic [31:0] opA, opB, aluResult, pcPlus4, nextPcComb;
    logic [4:0]  shamt;
    logic        taken;

    assign opA     = isAuipc ? pc : (isLui ? 32'b0 : rs1Val);
    assign opB     = useImm ? imm : rs2Val;
    assign shamt   = opB[4:0];
    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (aluCtrl)
            rvPkg::ADD:   aluResult = opA + opB;
            rvPkg::SUB:   aluResult = opA - opB;
            rvPkg::SLL:   aluResult = opA << shamt;
            rvPkg::SRL:   aluResult = opA >> shamt;
            rvPkg::SRA:   aluResult = $signed(opA) >>> shamt;
            rvPkg::SLT:   aluResult = {31'b0, $signed(opA) < $signed(opB)};
            rvPkg::SLTU:  aluResult = {31'b0, opA < opB};
            rvPkg::XOR:   aluResult = opA ^ opB;
            rvPkg::OR:    aluResult = opA | opB;
            rvPkg::AND:   aluResult = opA & opB;
            rvPkg::PASSB: aluResult = opB; // LUI
            default:      aluResult = 32'b0;
        endcase
    end

    always_comb begin
        case (branchCmd)
            rvPkg::BEQ:  taken = rs1Val == rs2Val;
            rvPkg::BNE:  taken = rs1Val != rs2Val;
            rvPkg::BLT:  taken = $signed(rs1Val) < $signed(rs2Val);
            rvPkg::BGE:  taken = $signed(rs1Val) >= $signed(rs2Val);
            rvPkg::BLTU: taken = rs1Val < rs2Val;
            rvPkg::BGEU: taken = rs1Val >= rs2Val;
            default:     taken = 1'b0;
        endcase
    end

    always_comb begin
        if (illegal) nextPcComb = pc; // PC holds on illegal
        else if (isJalr) nextPcComb = (rs1Val + imm) & ~32'd1;
        else if (isJal || (isBranch && taken)) nextPcComb = pc + imm;
        else nextPcComb = pcPlus4;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            commit <= 1'b0;
        end else begin
            commit <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            rdAddr     <= rd;
            rdData     <= (isJal || isJalr) ? pcPlus4 : aluResult; // Link value for jumps
            rdWrite    <= writesRd && !illegal;
            nextPc     <= nextPcComb;
            illegalOut <= illegal;
        end
    end

    // Register holds one item, so no new issue in the commit cycle
    assert property (@(posedge clk) disable iff (!rstN) commit |-> !issue)
        else $error("issue arrived while the previous result commits");

endmodule

//--- source/instrDecode.sv
`timescale 1ns/100ps

module instrDecode (
    input  logic [31:0]     instrWord,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2,
    output logic [4:0]      rd,
    output rvPkg::AluCtrl   aluCtrl,
    output rvPkg::BranchCmd branchCmd,
    output logic [31:0]     imm,
    output logic            useImm,
    output logic            isBranch,
    output logic            isJal,
    output logic            isJalr,
    output logic            isAuipc,
    output logic            isLui,
    output logic            writesRd,
    output logic            illegal
);

    rvPkg::OpCode  opCode;
    rvPkg::AluCtrl aluF3;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    logic [31:0]   immI, immB, immJ, immU;
    logic          opF7Bad;
    logic          shiftF7Bad;

    assign opCode = rvPkg::OpCode'(instrWord[6:2]);
    assign funct3 = instrWord[14:12];
    assign funct7 = instrWord[31:25];
    assign rd     = instrWord[11:7];
    assign rs1    = instrWord[19:15];
    assign rs2    = instrWord[24:20];

    assign immI = {{20{instrWord[31]}}, instrWord[31:20]};
    assign immB = {{19{instrWord[31]}}, instrWord[31], instrWord[7], instrWord[30:25],
                   instrWord[11:8], 1'b0};
    assign immJ = {{11{instrWord[31]}}, instrWord[31], instrWord[19:12], instrWord[20],
                   instrWord[30:21], 1'b0};
    assign immU = {instrWord[31:12], 12'b0};

    // Alternate funct7 only allowed on ADD/SUB and SRL/SRA
    assign opF7Bad = !(funct7 == 7'b0000000 ||
                       (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
    assign shiftF7Bad = (funct3 == 3'b001 && funct7 != 7'b0000000) ||
                        (funct3 == 3'b101 && funct7 != 7'b0000000 && funct7 != 7'b0100000);

    always_comb begin
        case (funct3)
            3'b000:  aluF3 = (opCode == rvPkg::OP && funct7[5]) ? rvPkg::SUB : rvPkg::ADD;
            3'b001:  aluF3 = rvPkg::SLL;
            3'b010:  aluF3 = rvPkg::SLT;
            3'b011:  aluF3 = rvPkg::SLTU;
            3'b100:  aluF3 = rvPkg::XOR;
            3'b101:  aluF3 = funct7[5] ? rvPkg::SRA : rvPkg::SRL;
            3'b110:  aluF3 = rvPkg::OR;
            default: aluF3 = rvPkg::AND;
        endcase
    end

    always_comb begin
        aluCtrl   = rvPkg::ADD;
        branchCmd = rvPkg::BranchCmd'(funct3);
        imm       = immI;
        useImm    = 1'b0;
        isBranch  = 1'b0;
        isJal     = 1'b0;
        isJalr    = 1'b0;
        isAuipc   = 1'b0;
        isLui     = 1'b0;
        writesRd  = 1'b0;
        illegal   = (instrWord[1:0] != 2'b11); // Compressed or reserved encoding
        case (opCode)
            rvPkg::OP: begin
                aluCtrl  = aluF3;
                writesRd = 1'b1;
                illegal  = illegal || opF7Bad;
            end
            rvPkg::OP_IMM: begin
                aluCtrl  = aluF3;
                useImm   = 1'b1;
                writesRd = 1'b1;
                illegal  = illegal || shiftF7Bad;
            end
            rvPkg::LUI: begin
                aluCtrl  = rvPkg::PASSB;
                imm      = immU;
                useImm   = 1'b1;
                isLui    = 1'b1;
                writesRd = 1'b1;
            end
            rvPkg::AUIPC: begin
                imm      = immU;
                useImm   = 1'b1;
                isAuipc  = 1'b1;
                writesRd = 1'b1;
            end
            rvPkg::BRANCH: begin
                imm      = immB;
                isBranch = 1'b1;
                illegal  = illegal || funct3[2:1] == 2'b01; // No branch on funct3 010/011
            end
            rvPkg::JAL: begin
                imm      = immJ;
                isJal    = 1'b1;
                writesRd = 1'b1;
            end
            rvPkg::JALR: begin
                isJalr   = 1'b1;
                writesRd = 1'b1;
                illegal  = illegal || funct3 != 3'b000;
            end
            default: illegal = 1'b1; // LOAD, STORE, SYSTEM and unknown
        endcase
        if (illegal) begin
            writesRd = 1'b0;
        end
    end

endmodule

//--- source/rvPkg.sv
package rvPkg;

    // RV32I major opcodes, instr[6:2]
    typedef enum logic [4:0] {
        LOAD   = 5'b00000,
        STORE  = 5'b01000,
        OP_IMM = 5'b00100, // Register-immediate ALU ops
        OP     = 5'b01100, // Register-register ALU ops
        LUI    = 5'b01101,
        AUIPC  = 5'b00101,
        BRANCH = 5'b11000,
        JAL    = 5'b11011,
        JALR   = 5'b11001,
        SYSTEM = 5'b11100  // ECALL, EBREAK, CSRs
    } OpCode;

    typedef enum logic [3:0] {
        ADD   = 4'd0,
        SUB   = 4'd1,
        SLL   = 4'd2,
        SRL   = 4'd3,
        SRA   = 4'd4, // Sign bit fills vacated bits
        SLT   = 4'd5,
        SLTU  = 4'd6,
        XOR   = 4'd7,
        OR    = 4'd8,
        AND   = 4'd9,
        PASSB = 4'd10 // Operand B straight through
    } AluCtrl;

    // Encoded as funct3 of BRANCH
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } BranchCmd;

    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        ISSUE      = 2'd1,
        WAITCOMMIT = 2'd2,
        ACK        = 2'd3
    } PortState;

    // Word address map of the bus port
    localparam logic [5:0] adrInstr   = 6'd0;  // Write issues, read gives status
    localparam logic [5:0] adrPc      = 6'd1;
    localparam logic [5:0] adrRegBase = 6'd32; // x0..x31 at 32..63

endpackage
